// File: nd_pkg.sv
// Memory subsystem widths, board window, timing constants and access structs
package nd_pkg;

  // ********************
  // Widths and window
  // ********************
  localparam int PADDR_W    = 24;        // Physical address bits
  localparam int DATA_W     = 16;        // Word size
  localparam int WIN_W      = 5;         // Top address bits for board select
  localparam int RAM_ADDR_W = 8;         // On-board RAM word address

  localparam logic [WIN_W-1:0] BOARD_BASE = 5'b00010; // Window this board answers to

  // ********************
  // Timing
  // ********************
  localparam int RAM_ACCESS_CYCLES = 2;  // Grant to done for read or write
  localparam int REFRESH_INTERVAL  = 64; // Cycles between refresh requests
  localparam int REFRESH_CYCLES    = 3;  // RAM busy time per refresh

  localparam int REF_CNT_W = $clog2(REFRESH_INTERVAL); // Interval counter width
  localparam int SEQ_CNT_W = $clog2(((REFRESH_CYCLES > RAM_ACCESS_CYCLES) ?
                                     REFRESH_CYCLES : RAM_ACCESS_CYCLES) + 1);

  // Client side access
  typedef struct packed {
    logic               write;           // 1 = write, 0 = read
    logic [PADDR_W-1:0] addr;            // Full physical address
    logic [DATA_W-1:0]  wdata;           // Write word
  } mem_req_t;

  // Client side result
  typedef struct packed {
    logic [DATA_W-1:0] rdata;            // Read word, zero on write
    logic              err;              // Out of board window
  } mem_rsp_t;

  // Word access as seen by the RAM
  typedef struct packed {
    logic                  write;
    logic [RAM_ADDR_W-1:0] addr;         // Word select, low address bits
    logic [DATA_W-1:0]     wdata;
  } ram_req_t;

endpackage

// File: mem_port.sv
// Requester port with four-phase client handshake and board window decode
module mem_port (
  input  logic                      sysclk,   // System clock
  input  logic                      rst_n,    // Async reset, active low
  input  logic                      req,      // Client request
  output logic                      ack,      // Response valid
  input  nd_pkg::mem_req_t          req_in,   // Client access, stable while req
  output nd_pkg::mem_rsp_t          rsp,      // Result, stable while ack
  output logic                      arb_req,  // RAM request to arbiter
  output nd_pkg::ram_req_t          ram_req,  // Word access for the RAM
  input  logic                      gnt_done, // Our granted access finished
  input  logic [nd_pkg::DATA_W-1:0] rdata     // Read word from RAM
);

  typedef enum logic [1:0] {
    ST_IDLE,                                  // Waiting for req
    ST_ARB,                                   // Decode, then wait for the RAM
    ST_ACK                                    // Holding ack until req drops
  } state_e;

  state_e           state_q;
  nd_pkg::mem_req_t req_q;                    // Captured client access
  nd_pkg::mem_rsp_t rsp_q;                    // Response register
  logic             win_hit;                  // Address inside board window

  // Top address bits against board base
  assign win_hit = (req_q.addr[nd_pkg::PADDR_W-1 -: nd_pkg::WIN_W] == nd_pkg::BOARD_BASE);

  assign ack     = (state_q == ST_ACK);
  assign rsp     = rsp_q;
  assign arb_req = (state_q == ST_ARB) && win_hit; // Out-of-window never arbitrates

  // Drop the window bits, RAM aliases modulo 256 words
  assign ram_req.write = req_q.write;
  assign ram_req.addr  = req_q.addr[nd_pkg::RAM_ADDR_W-1:0];
  assign ram_req.wdata = req_q.wdata;

  // ********************
  // Handshake FSM
  // ********************
  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (req) state_q <= ST_ARB;                    // Request seen
        ST_ARB:  if (!win_hit || gnt_done) state_q <= ST_ACK;   // Error or done
        ST_ACK:  if (!req) state_q <= ST_IDLE;                  // Client released
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Request capture and response latch
  always_ff @(posedge sysclk) begin
    if (state_q == ST_IDLE && req) begin
      req_q <= req_in;
    end
    if (state_q == ST_ARB) begin
      if (!win_hit) begin
        rsp_q.rdata <= '0;                    // Not our board
        rsp_q.err   <= 1'b1;
      end else if (gnt_done) begin
        rsp_q.rdata <= req_q.write ? '0 : rdata;
        rsp_q.err   <= 1'b0;
      end
    end
  end

endmodule

// File: refresh_timer.sv
// Refresh interval counter with held refresh request
module refresh_timer (
  input  logic sysclk,    // System clock
  input  logic rst_n,     // Async reset, active low
  output logic ref_req,   // Refresh wanted, held until done
  input  logic ref_done   // Refresh cycle finished
);

  logic [nd_pkg::REF_CNT_W-1:0] cnt_q;   // Cycles since last refresh

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q   <= '0;
      ref_req <= 1'b0;
    end else if (ref_req) begin
      if (ref_done) begin
        ref_req <= 1'b0;                  // Interval restarts here
        cnt_q   <= '0;
      end
    end else if (cnt_q == nd_pkg::REF_CNT_W'(nd_pkg::REFRESH_INTERVAL - 1)) begin
      ref_req <= 1'b1;                    // Interval elapsed
      cnt_q   <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

// File: mem_arbiter.sv
// RAM grant logic for refresh, CPU and backplane with request mux
module mem_arbiter (
  input  logic             sysclk,       // System clock
  input  logic             rst_n,        // Async reset, active low
  input  logic             cpu_arb_req,  // CPU port wants the RAM
  input  logic             bus_arb_req,  // Backplane port wants the RAM
  input  logic             ref_req,      // Refresh wants the RAM
  input  nd_pkg::ram_req_t cpu_ram_req,  // CPU word access
  input  nd_pkg::ram_req_t bus_ram_req,  // Backplane word access
  output logic             cpu_done,     // CPU access finished
  output logic             bus_done,     // Backplane access finished
  output logic             ref_done,     // Refresh finished
  output logic             ram_start,    // Start pulse to RAM
  output logic             ram_refresh,  // Current RAM cycle is refresh
  output nd_pkg::ram_req_t ram_req,      // Selected access
  input  logic             ram_done,     // RAM cycle finished
  output logic             cpu_gnt_led,  // CPU grant indicator
  output logic             bus_gnt_led   // Bus grant indicator
);

  typedef enum logic [1:0] {OWN_NONE, OWN_REF, OWN_CPU, OWN_BUS} owner_e;

  owner_e owner_q;                       // Current RAM owner
  logic   last_bus_q;                    // Backplane had the last port grant

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      owner_q    <= OWN_NONE;
      last_bus_q <= 1'b1;                // CPU goes first on a tie
      ram_start  <= 1'b0;
    end else begin
      ram_start <= 1'b0;
      if (owner_q == OWN_NONE) begin
        if (ref_req) begin               // Refresh beats both ports
          owner_q   <= OWN_REF;
          ram_start <= 1'b1;
        end else if (cpu_arb_req && (!bus_arb_req || last_bus_q)) begin
          owner_q    <= OWN_CPU;
          last_bus_q <= 1'b0;
          ram_start  <= 1'b1;
        end else if (bus_arb_req) begin
          owner_q    <= OWN_BUS;
          last_bus_q <= 1'b1;
          ram_start  <= 1'b1;
        end
      end else if (ram_done) begin
        owner_q <= OWN_NONE;             // Grant released with done
      end
    end
  end

  assign ram_refresh = (owner_q == OWN_REF);
  assign ram_req     = (owner_q == OWN_BUS) ? bus_ram_req : cpu_ram_req;
  assign cpu_done    = ram_done && (owner_q == OWN_CPU);  // Done back to owner
  assign bus_done    = ram_done && (owner_q == OWN_BUS);
  assign ref_done    = ram_done && (owner_q == OWN_REF);
  assign cpu_gnt_led = (owner_q == OWN_CPU);
  assign bus_gnt_led = (owner_q == OWN_BUS);

endmodule

// File: ram_ctrl.sv
// On-board RAM array with fixed-length access and refresh sequencer
module ram_ctrl (
  input  logic                      sysclk,       // System clock
  input  logic                      rst_n,        // Async reset, active low
  input  logic                      ram_start,    // Begin a RAM cycle
  input  logic                      ram_refresh,  // Cycle is a refresh
  input  nd_pkg::ram_req_t          ram_req,      // Access for this cycle
  output logic                      ram_done,     // Cycle finished, one pulse
  output logic [nd_pkg::DATA_W-1:0] rdata         // Read word, valid with done
);

  logic [nd_pkg::DATA_W-1:0]    mem_q [2**nd_pkg::RAM_ADDR_W]; // Word array
  logic [nd_pkg::SEQ_CNT_W-1:0] cnt_q;       // Cycles left, zero when idle
  nd_pkg::ram_req_t             req_q;       // Access held for the cycle
  logic                         refresh_q;   // Held refresh flag
  logic                         last_cyc;    // Final busy cycle

  assign last_cyc = (cnt_q == nd_pkg::SEQ_CNT_W'(1));

  // ********************
  // Cycle sequencer
  // ********************
  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q    <= '0;
      ram_done <= 1'b0;
    end else begin
      if (ram_start) begin
        // Load length, done lands exactly that many cycles after start
        cnt_q <= ram_refresh ? nd_pkg::SEQ_CNT_W'(nd_pkg::REFRESH_CYCLES - 1)
                             : nd_pkg::SEQ_CNT_W'(nd_pkg::RAM_ACCESS_CYCLES - 1);
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
      ram_done <= last_cyc;               // One pulse after last busy cycle
    end
  end

  // ********************
  // Array access
  // ********************
  always_ff @(posedge sysclk) begin
    if (ram_start) begin
      req_q     <= ram_req;
      refresh_q <= ram_refresh;
    end
    if (last_cyc && !refresh_q) begin     // Refresh only burns cycles
      if (req_q.write) begin
        mem_q[req_q.addr] <= req_q.wdata;
      end else begin
        rdata <= mem_q[req_q.addr];
      end
    end
  end

endmodule

// File: nd_mem_top.sv
// Memory subsystem top with CPU and backplane ports, refresh, arbiter and RAM
module nd_mem_top (
  input  logic             sysclk,       // System clock
  input  logic             rst_n,        // Async reset, active low
  input  logic             cpu_req,      // CPU side handshake
  output logic             cpu_ack,
  input  nd_pkg::mem_req_t cpu_req_in,
  output nd_pkg::mem_rsp_t cpu_rsp,
  input  logic             bus_req,      // Backplane side handshake
  output logic             bus_ack,
  input  nd_pkg::mem_req_t bus_req_in,
  output nd_pkg::mem_rsp_t bus_rsp,
  output logic             cpu_gnt_led,  // CPU grant indicator
  output logic             bus_gnt_led   // Bus grant indicator
);

  logic                      cpu_arb_req, bus_arb_req, ref_req;
  logic                      cpu_done, bus_done, ref_done;
  logic                      ram_start, ram_refresh, ram_done;
  nd_pkg::ram_req_t          cpu_ram_req, bus_ram_req, ram_req;
  logic [nd_pkg::DATA_W-1:0] ram_rdata;  // Shared read word to both ports

  // ********************
  // Requesters
  // ********************
  mem_port cpu_port_i (
    .sysclk (sysclk), .rst_n(rst_n), .req(cpu_req), .ack(cpu_ack),
    .req_in (cpu_req_in), .rsp(cpu_rsp), .arb_req(cpu_arb_req),
    .ram_req(cpu_ram_req), .gnt_done(cpu_done), .rdata(ram_rdata)
  );

  mem_port bus_port_i (
    .sysclk (sysclk), .rst_n(rst_n), .req(bus_req), .ack(bus_ack),
    .req_in (bus_req_in), .rsp(bus_rsp), .arb_req(bus_arb_req),
    .ram_req(bus_ram_req), .gnt_done(bus_done), .rdata(ram_rdata)
  );

  refresh_timer refresh_timer_i (
    .sysclk(sysclk), .rst_n(rst_n), .ref_req(ref_req), .ref_done(ref_done)
  );

  // ********************
  // Grant and RAM
  // ********************
  mem_arbiter mem_arbiter_i (
    .sysclk     (sysclk),      .rst_n      (rst_n),
    .cpu_arb_req(cpu_arb_req), .bus_arb_req(bus_arb_req), .ref_req (ref_req),
    .cpu_ram_req(cpu_ram_req), .bus_ram_req(bus_ram_req),
    .cpu_done   (cpu_done),    .bus_done   (bus_done),    .ref_done(ref_done),
    .ram_start  (ram_start),   .ram_refresh(ram_refresh), .ram_req (ram_req),
    .ram_done   (ram_done),    .cpu_gnt_led(cpu_gnt_led), .bus_gnt_led(bus_gnt_led)
  );

  ram_ctrl ram_ctrl_i (
    .sysclk   (sysclk),    .rst_n      (rst_n),
    .ram_start(ram_start), .ram_refresh(ram_refresh), .ram_req(ram_req),
    .ram_done (ram_done),  .rdata      (ram_rdata)
  );

endmodule

// File: tb_clock_gen.sv
// Testbench clock and reset generator
module tb_clock_gen (
  output logic sysclk,  // 20 ns period
  output logic rst_n    // Low for the first two rising edges
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD = 10;  // ns

  initial begin
    sysclk = 1'b0;
    forever #(HALF_PERIOD) sysclk = ~sysclk;
  end

  initial begin
    rst_n = 1'b0;
    #(4 * HALF_PERIOD) rst_n = 1'b1;  // Released on a falling edge
  end

endmodule

// File: nd_mem_checker.sv
// Grant exclusivity, RAM start and client handshake assertions with their bind
module nd_mem_checker (
  input logic sysclk, rst_n,
  input logic cpu_req, cpu_ack, bus_req, bus_ack,  // Client handshakes
  input logic cpu_gnt_led, bus_gnt_led,            // Port grants
  input logic ram_start, ram_done                  // Arbiter to RAM and back
);
  timeunit 1ns;
  timeprecision 100ps;

  int   fail_cnt = 0;  // Failed assertions so far
  logic ram_busy_q;    // RAM cycle between start and done

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      ram_busy_q <= 1'b0;
    end else if (ram_start) begin
      ram_busy_q <= 1'b1;
    end else if (ram_done) begin
      ram_busy_q <= 1'b0;
    end
  end

  a_one_grant: assert property (@(posedge sysclk) disable iff (!rst_n)
    !(cpu_gnt_led && bus_gnt_led))
    else begin
      fail_cnt++;
      $error("Both grant LEDs high at once");
    end

  // No new start until the RAM reported done
  a_start_idle: assert property (@(posedge sysclk) disable iff (!rst_n)
    ram_start |-> !ram_busy_q)
    else begin
      fail_cnt++;
      $error("RAM start issued while the RAM was busy");
    end

  a_cpu_hold: assert property (@(posedge sysclk) disable iff (!rst_n)
    (cpu_ack && cpu_req) |=> cpu_ack)
    else begin
      fail_cnt++;
      $error("CPU ack fell while req was high");
    end

  a_bus_hold: assert property (@(posedge sysclk) disable iff (!rst_n)
    (bus_ack && bus_req) |=> bus_ack)
    else begin
      fail_cnt++;
      $error("Backplane ack fell while req was high");
    end

endmodule

bind nd_mem_top nd_mem_checker nd_mem_checker_i (
  .sysclk(sysclk), .rst_n(rst_n),
  .cpu_req(cpu_req), .cpu_ack(cpu_ack), .bus_req(bus_req), .bus_ack(bus_ack),
  .cpu_gnt_led(cpu_gnt_led), .bus_gnt_led(bus_gnt_led),
  .ram_start(ram_start), .ram_done(ram_done)
);

// File: tb_nd_mem.sv
// Testbench top with LCG stimulus, RAM reference model, compare tasks and verdict
module tb_nd_mem;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ACK_TIMEOUT = 200;  // Cycles per handshake phase
  localparam int N_RANDOM    = 80;   // Random accesses over both ports

  logic                      sysclk, rst_n;
  logic                      cpu_req, cpu_ack, bus_req, bus_ack, cpu_gnt_led, bus_gnt_led;
  nd_pkg::mem_req_t          cpu_req_in, bus_req_in;
  nd_pkg::mem_rsp_t          cpu_rsp, bus_rsp;
  logic [nd_pkg::DATA_W-1:0] model_mem [2**nd_pkg::RAM_ADDR_W];  // Expected RAM words
  nd_pkg::mem_req_t          rand_q[$];  // Random accesses
  bit                        port_q[$];  // 1 = backplane
  int                        hold_q[$];  // Extra cycles req stays high after ack
  logic [31:0]               lcg_state = 32'd55639;
  int                        val_errs  = 0;
  int                        timeouts  = 0;

  tb_clock_gen clk_gen_i (.sysclk(sysclk), .rst_n(rst_n));

  nd_mem_top dut_i (
    .sysclk(sysclk), .rst_n(rst_n),
    .cpu_req(cpu_req), .cpu_ack(cpu_ack), .cpu_req_in(cpu_req_in), .cpu_rsp(cpu_rsp),
    .bus_req(bus_req), .bus_ack(bus_ack), .bus_req_in(bus_req_in), .bus_rsp(bus_rsp),
    .cpu_gnt_led(cpu_gnt_led), .bus_gnt_led(bus_gnt_led)
  );

  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];  // Upper half, longer period
  endfunction

  function automatic nd_pkg::mem_req_t make_req(logic write, logic [nd_pkg::WIN_W-1:0] win,
                                                logic [10:0] hi, logic [4:0] word,
                                                logic [nd_pkg::DATA_W-1:0] wdata);
    nd_pkg::mem_req_t rq;
    rq.write = write;
    rq.addr  = {win, hi, 3'b000, word};  // 32-word region, bits 18:8 only alias
    rq.wdata = wdata;
    return rq;
  endfunction

  function automatic nd_pkg::mem_req_t rand_access();
    logic [15:0]              r, d, w;
    logic [nd_pkg::WIN_W-1:0] win;
    win = nd_pkg::BOARD_BASE;
    r   = lcg_next();
    if ((r % 16'd10) >= 16'd8) begin  // One in five misses the board
      win = (r[15:11] == nd_pkg::BOARD_BASE) ? ~nd_pkg::BOARD_BASE : r[15:11];
    end
    r = lcg_next();
    d = lcg_next();
    w = lcg_next();
    return make_req(r[15], win, r[10:0], w[4:0], d);
  endfunction

  task automatic check_rsp(string name, nd_pkg::mem_rsp_t got, nd_pkg::mem_rsp_t exp);
    if (got !== exp) begin
      val_errs++;
      $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_word(string name, logic [nd_pkg::DATA_W-1:0] got,
                            logic [nd_pkg::DATA_W-1:0] exp);
    if (got !== exp) begin
      val_errs++;
      $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_led(string name, logic got, logic exp);
    if (got !== exp) begin
      val_errs++;
      $display("ERR %0t %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  task automatic drive_req(bit is_bus, logic req, nd_pkg::mem_req_t rq);
    if (is_bus) begin
      bus_req    = req;
      bus_req_in = rq;
    end else begin
      cpu_req    = req;
      cpu_req_in = rq;
    end
  endtask

  task automatic wait_ack(bit is_bus, logic level, output logic gnt_seen);
    int n;
    n        = 0;
    gnt_seen = 1'b0;
    do begin
      @(negedge sysclk);
      n++;
      gnt_seen = gnt_seen | (is_bus ? bus_gnt_led : cpu_gnt_led);  // Port held the RAM
    end while ((is_bus ? bus_ack : cpu_ack) !== level && n < ACK_TIMEOUT);
    if ((is_bus ? bus_ack : cpu_ack) !== level) begin
      timeouts++;
      $display("Timeout: %s ack did not go to %b", is_bus ? "bus" : "cpu", level);
    end
  endtask

  // ********************
  // One four-phase handshake
  // ********************
  task automatic do_access(bit is_bus, nd_pkg::mem_req_t rq, int hold,
                           output nd_pkg::mem_rsp_t got);
    nd_pkg::mem_rsp_t exp;
    string            name;
    string            led_name;
    logic             gnt_seen;
    name     = is_bus ? "bus_rsp" : "cpu_rsp";
    led_name = is_bus ? "bus_gnt_led" : "cpu_gnt_led";
    drive_req(is_bus, 1'b1, rq);
    wait_ack(is_bus, 1'b1, gnt_seen);
    exp.err   = (rq.addr[nd_pkg::PADDR_W-1 -: nd_pkg::WIN_W] != nd_pkg::BOARD_BASE);
    exp.rdata = '0;  // Writes and misses read back zero
    if (!exp.err && rq.write) begin
      model_mem[rq.addr[nd_pkg::RAM_ADDR_W-1:0]] = rq.wdata;
    end else if (!exp.err) begin
      exp.rdata = model_mem[rq.addr[nd_pkg::RAM_ADDR_W-1:0]];
    end
    check_led(led_name, gnt_seen, !exp.err);  // Only board hits get the RAM
    got = is_bus ? bus_rsp : cpu_rsp;
    check_rsp(name, got, exp);
    repeat (hold) begin  // Response must stay put
      @(negedge sysclk);
      check_rsp(name, is_bus ? bus_rsp : cpu_rsp, exp);
    end
    drive_req(is_bus, 1'b0, rq);
    wait_ack(is_bus, 1'b0, gnt_seen);
  endtask

  task automatic run_port(bit is_bus);
    nd_pkg::mem_rsp_t got;
    foreach (rand_q[i]) begin
      if (port_q[i] == is_bus) do_access(is_bus, rand_q[i], hold_q[i], got);
    end
  endtask

  initial begin
    nd_pkg::mem_req_t rq;
    nd_pkg::mem_rsp_t got;
    logic [15:0]      r;
    int               n;
    int               chk_errs;
    cpu_req    = 1'b0;
    bus_req    = 1'b0;
    cpu_req_in = '0;
    bus_req_in = '0;
    n = 0;
    do begin
      @(negedge sysclk);
      n++;
    end while (rst_n !== 1'b1 && n < 10);
    if (rst_n !== 1'b1) begin
      timeouts++;
      $display("Timeout: reset was never released");
    end

    for (int w = 0; w < 32; w++) begin  // Fill the region from both ports
      r = lcg_next();
      do_access(w[0], make_req(1'b1, nd_pkg::BOARD_BASE, r[10:0], w[4:0], lcg_next()), 0, got);
    end

    // ********************
    // Directed cases
    // ********************
    rq = make_req(1'b1, nd_pkg::BOARD_BASE, 11'h123, 5'd7, 16'hbeef);
    do_access(1'b0, rq, 0, got);
    rq.write = 1'b0;
    do_access(1'b0, rq, 0, got);
    check_word("cpu_rsp.rdata", got.rdata, 16'hbeef);
    rq = make_req(1'b1, 5'b10010, 11'h123, 5'd7, 16'h5a5a);  // Foreign window
    do_access(1'b1, rq, 0, got);
    rq = make_req(1'b0, nd_pkg::BOARD_BASE, 11'h6d5, 5'd7, '0);  // Alias, req held long
    do_access(1'b1, rq, 3, got);
    check_word("bus_rsp.rdata", got.rdata, 16'hbeef);
    rq = make_req(1'b1, nd_pkg::BOARD_BASE, 11'h7ff, 5'd7, 16'h1234);
    do_access(1'b0, rq, 2, got);
    rq = make_req(1'b0, nd_pkg::BOARD_BASE, 11'h000, 5'd7, '0);
    do_access(1'b1, rq, 0, got);
    check_word("bus_rsp.rdata", got.rdata, 16'h1234);

    // Both ports busy at once, long enough for several refreshes
    for (int i = 0; i < N_RANDOM; i++) begin
      rand_q.push_back(rand_access());
      r = lcg_next();
      port_q.push_back(r[15]);
      hold_q.push_back((r[1:0] == 2'b11) ? 2 : 0);
    end
    fork
      run_port(1'b0);
      run_port(1'b1);
    join

    chk_errs = dut_i.nd_mem_checker_i.fail_cnt;
    $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             val_errs, timeouts, chk_errs);
    if (val_errs == 0 && timeouts == 0 && chk_errs == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
nd_pkg.sv
mem_port.sv
refresh_timer.sv
mem_arbiter.sv
ram_ctrl.sv
nd_mem_top.sv
tb_clock_gen.sv
nd_mem_checker.sv
tb_nd_mem.sv

// File: run.sh
#!/bin/sh
# Compile and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_nd_mem -f vlog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_nd_mem +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
  echo "No verdict found in sim.log"
  exit 1
fi
exit 0
